//--- logic/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // jal writes its return address here
    localparam reg_addr_t LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_EIGHT, SRC2_ZIMM} src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } bypass_t;

    typedef struct packed {
        bypass_t fwd;
        logic    is_load;
    } ex_bypass_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     instr;
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      mem_en;
        logic      mem_we;
        logic      reg_we;
        reg_addr_t dest;
        word_t     op1;
        word_t     op2;
    } id_to_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  decode_pkg::bypass_t         wb,
    input  decode_pkg::reg_addr_t [1:0] raddr,
    output decode_pkg::word_t     [1:0] rdata
);
    import decode_pkg::*;

    word_t regs [32];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

//--- logic/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
    input  decode_pkg::reg_addr_t  addr,
    input  decode_pkg::word_t      rf_data,
    input  decode_pkg::ex_bypass_t ex_fwd,
    input  decode_pkg::bypass_t    mem_fwd,
    input  decode_pkg::bypass_t    wb_fwd,
    output decode_pkg::word_t      data
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    assign ex_hit  = ex_fwd.fwd.we && (ex_fwd.fwd.waddr == addr);
    assign mem_hit = mem_fwd.we && (mem_fwd.waddr == addr);
    assign wb_hit  = wb_fwd.we && (wb_fwd.waddr == addr);

    // youngest producer wins
    always_comb begin
        if (addr == '0) begin
            data = '0;
        end else if (ex_hit) begin
            data = ex_fwd.fwd.wdata;
        end else if (mem_hit) begin
            data = mem_fwd.wdata;
        end else if (wb_hit) begin
            data = wb_fwd.wdata;
        end else begin
            data = rf_data;
        end
    end

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  decode_pkg::br_kind_e br_kind,
    input  decode_pkg::word_t    pc,
    input  logic [15:0]          imm,
    input  logic [25:0]          instr_index,
    input  decode_pkg::word_t    rs_val,
    input  decode_pkg::word_t    rt_val,
    output decode_pkg::branch_t  branch
);
    import decode_pkg::*;

    word_t pc_plus_4;
    word_t br_target;
    word_t jump_target;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;

    assign pc_plus_4   = pc + 32'd4;
    assign br_target   = pc_plus_4 + {{14{imm[15]}}, imm, 2'b00};
    // stays inside the current 256 MB region
    assign jump_target = {pc_plus_4[31:28], instr_index, 2'b00};

    assign rs_eq_rt = (rs_val == rt_val);
    assign rs_neg   = rs_val[31];
    assign rs_zero  = (rs_val == '0);

    always_comb begin
        branch.taken  = 1'b0;
        branch.target = br_target;
        case (br_kind)
            BR_BEQ:  branch.taken = rs_eq_rt;
            BR_BNE:  branch.taken = !rs_eq_rt;
            BR_BGEZ: branch.taken = !rs_neg;
            BR_BGTZ: branch.taken = !rs_neg && !rs_zero;
            BR_BLEZ: branch.taken = rs_neg || rs_zero;
            BR_BLTZ: branch.taken = rs_neg;
            BR_J, BR_JAL: begin
                branch.taken  = 1'b1;
                branch.target = jump_target;
            end
            BR_JR, BR_JALR: begin
                branch.taken  = 1'b1;
                branch.target = rs_val;
            end
            default: branch.taken = 1'b0;
        endcase
    end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  decode_pkg::fetch_t     fetch,
    input  logic                   stall,
    input  decode_pkg::ex_bypass_t ex_fwd,
    input  decode_pkg::word_t      rs_data,
    input  decode_pkg::word_t      rt_data,
    output decode_pkg::reg_addr_t  rs_addr,
    output decode_pkg::reg_addr_t  rt_addr,
    output decode_pkg::id_to_ex_t  id_to_ex,
    output decode_pkg::br_kind_e   br_kind,
    output decode_pkg::word_t      pc,
    output logic [15:0]            imm,
    output logic [25:0]            instr_index,
    output logic                   stallreq
);
    import decode_pkg::*;

    fetch_t    fetch_q;
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rd;
    logic      load_hit;
    logic      issue;
    alu_op_e   r_alu_op;
    alu_op_e   i_alu_op;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      mem_en;
    logic      mem_we;
    logic      reg_we;
    reg_addr_t dest;
    br_kind_e  kind;

    // hold on downstream stall or our own load-use bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q.valid <= 1'b0;
        end else if (!stall && !stallreq) begin
            fetch_q <= fetch;
        end
    end

    assign opcode      = opcode_e'(fetch_q.instr[31:26]);
    assign rs_addr     = fetch_q.instr[25:21];
    assign rt_addr     = fetch_q.instr[20:16];
    assign rd          = fetch_q.instr[15:11];
    assign funct       = funct_e'(fetch_q.instr[5:0]);
    assign imm         = fetch_q.instr[15:0];
    assign instr_index = fetch_q.instr[25:0];
    assign pc          = fetch_q.pc;

    // load in execute produces its data too late to forward
    assign load_hit = ex_fwd.fwd.we && ex_fwd.is_load && (ex_fwd.fwd.waddr != '0) &&
                      (ex_fwd.fwd.waddr == rs_addr || ex_fwd.fwd.waddr == rt_addr);
    assign stallreq = fetch_q.valid && load_hit;
    assign issue    = fetch_q.valid && !load_hit;

    always_comb begin
        case (funct)
            FN_SLL:  r_alu_op = ALU_SLL;
            FN_SRL:  r_alu_op = ALU_SRL;
            FN_SRA:  r_alu_op = ALU_SRA;
            FN_ADDU: r_alu_op = ALU_ADD;
            FN_SUBU: r_alu_op = ALU_SUB;
            FN_AND:  r_alu_op = ALU_AND;
            FN_OR:   r_alu_op = ALU_OR;
            FN_XOR:  r_alu_op = ALU_XOR;
            FN_NOR:  r_alu_op = ALU_NOR;
            FN_SLT:  r_alu_op = ALU_SLT;
            FN_SLTU: r_alu_op = ALU_SLTU;
            // link address pc + 8 goes through the adder
            FN_JALR: r_alu_op = ALU_ADD;
            default: r_alu_op = ALU_NONE;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ADDIU, OP_LW, OP_SW: i_alu_op = ALU_ADD;
            OP_SLTI:  i_alu_op = ALU_SLT;
            OP_SLTIU: i_alu_op = ALU_SLTU;
            OP_ANDI:  i_alu_op = ALU_AND;
            OP_ORI:   i_alu_op = ALU_OR;
            OP_XORI:  i_alu_op = ALU_XOR;
            OP_LUI:   i_alu_op = ALU_LUI;
            default:  i_alu_op = ALU_NONE;
        endcase
    end

    always_comb begin
        alu_op   = ALU_NONE;
        src1_sel = SRC1_RS;
        src2_sel = SRC2_RT;
        mem_en   = 1'b0;
        mem_we   = 1'b0;
        reg_we   = 1'b0;
        dest     = '0;
        kind     = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                alu_op = r_alu_op;
                reg_we = (r_alu_op != ALU_NONE);
                dest   = rd;
                if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
                    src1_sel = SRC1_SA;
                end
                if (funct == FN_JALR) begin
                    src1_sel = SRC1_PC;
                    src2_sel = SRC2_EIGHT;
                    kind     = BR_JALR;
                end else if (funct == FN_JR) begin
                    kind = BR_JR;
                end
            end
            OP_REGIMM: begin
                // rt selects the regimm variant
                if (rt_addr == 5'd0) begin
                    kind = BR_BLTZ;
                end else if (rt_addr == 5'd1) begin
                    kind = BR_BGEZ;
                end
            end
            OP_J:    kind = BR_J;
            OP_BEQ:  kind = BR_BEQ;
            OP_BNE:  kind = BR_BNE;
            OP_BLEZ: kind = BR_BLEZ;
            OP_BGTZ: kind = BR_BGTZ;
            OP_JAL: begin
                kind     = BR_JAL;
                alu_op   = ALU_ADD;
                src1_sel = SRC1_PC;
                src2_sel = SRC2_EIGHT;
                reg_we   = 1'b1;
                dest     = LINK_REG;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                alu_op = i_alu_op;
                // logical immediates are zero extended
                if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI) begin
                    src2_sel = SRC2_ZIMM;
                end else begin
                    src2_sel = SRC2_SIMM;
                end
                reg_we = 1'b1;
                dest   = rt_addr;
                mem_en = (opcode == OP_LW);
            end
            OP_SW: begin
                alu_op   = i_alu_op;
                src2_sel = SRC2_SIMM;
                mem_en   = 1'b1;
                mem_we   = 1'b1;
            end
            default: kind = BR_NONE;
        endcase
    end

    always_comb begin
        id_to_ex.valid    = issue;
        id_to_ex.pc       = fetch_q.pc;
        id_to_ex.instr    = fetch_q.instr;
        id_to_ex.alu_op   = alu_op;
        id_to_ex.src1_sel = src1_sel;
        id_to_ex.src2_sel = src2_sel;
        id_to_ex.mem_en   = mem_en;
        id_to_ex.mem_we   = mem_we;
        id_to_ex.reg_we   = reg_we;
        id_to_ex.dest     = dest;
        id_to_ex.op1      = rs_data;
        id_to_ex.op2      = rt_data;
    end

    assign br_kind = issue ? kind : BR_NONE;

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  decode_pkg::fetch_t     fetch,
    input  logic                   stall,
    input  decode_pkg::ex_bypass_t ex_fwd,
    input  decode_pkg::bypass_t    mem_fwd,
    input  decode_pkg::bypass_t    wb_fwd,
    output decode_pkg::id_to_ex_t  id_to_ex,
    output decode_pkg::branch_t    branch,
    output logic                   stallreq
);
    import decode_pkg::*;

    // index 0 is rs, index 1 is rt
    reg_addr_t [1:0] raddr;
    word_t     [1:0] rf_rdata;
    word_t     [1:0] src_val;
    br_kind_e        br_kind;
    word_t           pc;
    logic [15:0]     imm;
    logic [25:0]     instr_index;

    instr_decoder instr_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .fetch       (fetch),
        .stall       (stall),
        .ex_fwd      (ex_fwd),
        .rs_data     (src_val[0]),
        .rt_data     (src_val[1]),
        .rs_addr     (raddr[0]),
        .rt_addr     (raddr[1]),
        .id_to_ex    (id_to_ex),
        .br_kind     (br_kind),
        .pc          (pc),
        .imm         (imm),
        .instr_index (instr_index),
        .stallreq    (stallreq)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .wb    (wb_fwd),
        .raddr (raddr),
        .rdata (rf_rdata)
    );

    for (genvar p = 0; p < 2; p++) begin : g_fwd
        operand_fwd operand_fwd_i (
            .addr    (raddr[p]),
            .rf_data (rf_rdata[p]),
            .ex_fwd  (ex_fwd),
            .mem_fwd (mem_fwd),
            .wb_fwd  (wb_fwd),
            .data    (src_val[p])
        );
    end

    branch_unit branch_unit_i (
        .br_kind     (br_kind),
        .pc          (pc),
        .imm         (imm),
        .instr_index (instr_index),
        .rs_val      (src_val[0]),
        .rt_val      (src_val[1]),
        .branch      (branch)
    );

endmodule

//--- verification/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk (
    input logic                  clk,
    input logic                  rst,
    input decode_pkg::id_to_ex_t id_to_ex,
    input decode_pkg::branch_t   branch,
    input logic                  stallreq
);

    // a load-use bubble keeps the same instruction for the retry
    stall_holds_instr: assert property (@(posedge clk) disable iff (rst)
        stallreq |=> ($stable(id_to_ex.pc) && $stable(id_to_ex.instr)))
        else $error("instruction changed while a load-use stall was requested");

    taken_needs_valid: assert property (@(posedge clk) disable iff (rst)
        branch.taken |-> id_to_ex.valid)
        else $error("branch taken without a valid instruction");

    reset_leaves_idle: assert property (@(posedge clk)
        rst |=> (!id_to_ex.valid && !branch.taken && !stallreq))
        else $error("output active in the cycle after reset");

endmodule

bind decode_stage decode_stage_chk decode_stage_chk_i (
    .clk      (clk),
    .rst      (rst),
    .id_to_ex (id_to_ex),
    .branch   (branch),
    .stallreq (stallreq)
);

//--- verification/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    // reset, decode with register load, forwarding, branches, load-use, hold
    localparam int TEST_CYCLES   = 2 + (2 * 31 + 2 * 6) + 6 + (2 * 5 + 2 * 13 + 2) + 4 + 8;
    localparam int MARGIN_CYCLES = 50;

    logic       clk;
    logic       rst;
    fetch_t     fetch;
    logic       stall;
    ex_bypass_t ex_fwd;
    bypass_t    mem_fwd;
    bypass_t    wb_fwd;
    id_to_ex_t  id_to_ex;
    branch_t    branch;
    logic       stallreq;

    word_t model [32];
    string cur_test;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    decode_stage decode_stage_i (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .stall    (stall),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .id_to_ex (id_to_ex),
        .branch   (branch),
        .stallreq (stallreq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
            input reg_addr_t rd, input logic [4:0] sa, input funct_e fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input reg_addr_t rs,
            input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input opcode_e op, input logic [25:0] index);
        return {op, index};
    endfunction

    // pc + 4 plus the word offset
    function automatic word_t cond_target(input word_t pc, input logic [15:0] imm);
        return pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    endfunction

    function automatic word_t jump_target(input word_t pc, input logic [25:0] index);
        word_t next_pc;
        next_pc = pc + 32'd4;
        return {next_pc[31:28], index, 2'b00};
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed", cur_test);
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic set_reg(input reg_addr_t r, input word_t val);
        @(posedge clk);
        wb_fwd <= '{we: 1'b1, waddr: r, wdata: val};
        @(posedge clk);
        wb_fwd <= '0;
        model[r] = val;
    endtask

    // outputs settle one cycle after the fetch, sampled mid-cycle
    task automatic present(input word_t pc, input word_t instr);
        @(posedge clk);
        fetch <= '{valid: 1'b1, pc: pc, instr: instr};
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_decode(input word_t instr, input alu_op_e alu, input src1_sel_e s1,
            input src2_sel_e s2, input logic mem_en, input logic mem_we, input logic reg_we,
            input reg_addr_t dest);
        check_word("valid", 32'd1, 32'(id_to_ex.valid));
        check_word("instr", instr, id_to_ex.instr);
        check_word("alu_op", 32'(alu), 32'(id_to_ex.alu_op));
        check_word("src1_sel", 32'(s1), 32'(id_to_ex.src1_sel));
        check_word("src2_sel", 32'(s2), 32'(id_to_ex.src2_sel));
        check_word("mem_en", 32'(mem_en), 32'(id_to_ex.mem_en));
        check_word("mem_we", 32'(mem_we), 32'(id_to_ex.mem_we));
        check_word("reg_we", 32'(reg_we), 32'(id_to_ex.reg_we));
        check_word("dest", 32'(dest), 32'(id_to_ex.dest));
        check_word("op1", model[instr[25:21]], id_to_ex.op1);
        check_word("op2", model[instr[20:16]], id_to_ex.op2);
    endtask

    task automatic branch_case(input string what, input word_t pc, input word_t instr,
            input logic taken, input word_t target);
        present(pc, instr);
        check_word({what, " valid"}, 32'd1, 32'(id_to_ex.valid));
        check_word({what, " taken"}, 32'(taken), 32'(branch.taken));
        if (taken) begin
            check_word({what, " target"}, target, branch.target);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        @(negedge clk);
        check_word("valid", 32'd0, 32'(id_to_ex.valid));
        check_word("taken", 32'd0, 32'(branch.taken));
        check_word("stallreq", 32'd0, 32'(stallreq));
        @(posedge clk);
        fetch <= '0;
        end_test();
    endtask

    task automatic test_decode();
        word_t instr [6];
        start_test("alu_mem_decode");
        for (int r = 1; r < 32; r++) begin
            set_reg(5'(r), $urandom);
        end
        instr[0] = r_type(5'd1, 5'd2, 5'd10, 5'd0, FN_ADDU);
        instr[1] = i_type(OP_ORI, 5'd3, 5'd11, 16'h8a5c);
        instr[2] = i_type(OP_LUI, 5'd0, 5'd12, 16'h1234);
        instr[3] = r_type(5'd0, 5'd4, 5'd13, 5'd7, FN_SLL);
        instr[4] = i_type(OP_LW, 5'd5, 5'd14, 16'hfffc);
        instr[5] = i_type(OP_SW, 5'd7, 5'd6, 16'h0010);
        present(32'h0000_0100, instr[0]);
        check_decode(instr[0], ALU_ADD, SRC1_RS, SRC2_RT, 1'b0, 1'b0, 1'b1, 5'd10);
        present(32'h0000_0104, instr[1]);
        check_decode(instr[1], ALU_OR, SRC1_RS, SRC2_ZIMM, 1'b0, 1'b0, 1'b1, 5'd11);
        present(32'h0000_0108, instr[2]);
        check_decode(instr[2], ALU_LUI, SRC1_RS, SRC2_SIMM, 1'b0, 1'b0, 1'b1, 5'd12);
        present(32'h0000_010c, instr[3]);
        check_decode(instr[3], ALU_SLL, SRC1_SA, SRC2_RT, 1'b0, 1'b0, 1'b1, 5'd13);
        present(32'h0000_0110, instr[4]);
        check_decode(instr[4], ALU_ADD, SRC1_RS, SRC2_SIMM, 1'b1, 1'b0, 1'b1, 5'd14);
        present(32'h0000_0114, instr[5]);
        check_decode(instr[5], ALU_ADD, SRC1_RS, SRC2_SIMM, 1'b1, 1'b1, 1'b0, 5'd0);
        end_test();
    endtask

    task automatic test_forwarding();
        word_t ex_val;
        word_t mem_val;
        word_t wb_val;
        ex_val  = $urandom;
        mem_val = $urandom;
        wb_val  = $urandom;
        start_test("forwarding");
        @(posedge clk);
        ex_fwd  <= '{fwd: '{we: 1'b1, waddr: 5'd9, wdata: ex_val}, is_load: 1'b0};
        mem_fwd <= '{we: 1'b1, waddr: 5'd9, wdata: mem_val};
        wb_fwd  <= '{we: 1'b1, waddr: 5'd9, wdata: wb_val};
        present(32'h0000_0200, r_type(5'd9, 5'd0, 5'd1, 5'd0, FN_ADDU));
        check_word("op1 from execute", ex_val, id_to_ex.op1);
        check_word("op2 register 0", 32'd0, id_to_ex.op2);
        @(posedge clk);
        ex_fwd <= '0;
        @(negedge clk);
        check_word("op1 from memory", mem_val, id_to_ex.op1);
        // writeback has already landed in the register file
        @(posedge clk);
        ex_fwd  <= '{fwd: '{we: 1'b1, waddr: 5'd0, wdata: ex_val}, is_load: 1'b0};
        mem_fwd <= '0;
        wb_fwd  <= '0;
        model[9] = wb_val;
        @(negedge clk);
        check_word("op1 from register file", wb_val, id_to_ex.op1);
        check_word("op2 register 0 with execute match", 32'd0, id_to_ex.op2);
        @(posedge clk);
        ex_fwd <= '0;
        end_test();
    endtask

    task automatic test_branches();
        word_t v;
        word_t w;
        v = $urandom;
        w = $urandom;
        start_test("branch_resolution");
        set_reg(5'd16, v);
        set_reg(5'd17, v);
        set_reg(5'd18, ~v);
        set_reg(5'd19, ($urandom & 32'h7fff_ffff) | 32'h1);
        set_reg(5'd20, $urandom | 32'h8000_0000);
        branch_case("beq equal", 32'h2000, i_type(OP_BEQ, 5'd16, 5'd17, 16'h0010),
            1'b1, cond_target(32'h2000, 16'h0010));
        branch_case("beq unequal", 32'h2004, i_type(OP_BEQ, 5'd16, 5'd18, 16'hfff8),
            1'b0, '0);
        branch_case("bne unequal", 32'h2008, i_type(OP_BNE, 5'd16, 5'd18, 16'hfff8),
            1'b1, cond_target(32'h2008, 16'hfff8));
        branch_case("bne equal", 32'h200c, i_type(OP_BNE, 5'd16, 5'd17, 16'h0010),
            1'b0, '0);
        branch_case("bgtz positive", 32'h2010, i_type(OP_BGTZ, 5'd19, 5'd0, 16'h0020),
            1'b1, cond_target(32'h2010, 16'h0020));
        branch_case("bgtz zero", 32'h2014, i_type(OP_BGTZ, 5'd0, 5'd0, 16'h0020), 1'b0, '0);
        branch_case("bgtz negative", 32'h2018, i_type(OP_BGTZ, 5'd20, 5'd0, 16'h0020),
            1'b0, '0);
        branch_case("bltz negative", 32'h201c, i_type(OP_REGIMM, 5'd20, 5'd0, 16'h8004),
            1'b1, cond_target(32'h201c, 16'h8004));
        branch_case("bltz positive", 32'h2020, i_type(OP_REGIMM, 5'd19, 5'd0, 16'h0004),
            1'b0, '0);
        branch_case("bltz zero", 32'h2024, i_type(OP_REGIMM, 5'd0, 5'd0, 16'h0004), 1'b0, '0);
        // pc + 4 crosses into the next 256 MB region
        branch_case("j", 32'h4fff_fffc, j_type(OP_J, 26'h0123456),
            1'b1, jump_target(32'h4fff_fffc, 26'h0123456));
        @(posedge clk);
        ex_fwd <= '{fwd: '{we: 1'b1, waddr: 5'd21, wdata: w}, is_load: 1'b0};
        branch_case("jr", 32'h2028, r_type(5'd21, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1, w);
        @(posedge clk);
        ex_fwd <= '0;
        branch_case("jal", 32'h3000, j_type(OP_JAL, 26'h0000400),
            1'b1, jump_target(32'h3000, 26'h0000400));
        check_word("jal src1_sel", 32'(SRC1_PC), 32'(id_to_ex.src1_sel));
        check_word("jal src2_sel", 32'(SRC2_EIGHT), 32'(id_to_ex.src2_sel));
        check_word("jal reg_we", 32'd1, 32'(id_to_ex.reg_we));
        check_word("jal dest", 32'd31, 32'(id_to_ex.dest));
        end_test();
    endtask

    task automatic test_load_use();
        word_t instr;
        instr = i_type(OP_BEQ, 5'd22, 5'd22, 16'h0008);
        start_test("load_use_stall");
        @(posedge clk);
        ex_fwd <= '{fwd: '{we: 1'b1, waddr: 5'd22, wdata: $urandom}, is_load: 1'b1};
        present(32'h0000_5000, instr);
        check_word("stallreq", 32'd1, 32'(stallreq));
        check_word("valid during stall", 32'd0, 32'(id_to_ex.valid));
        check_word("taken during stall", 32'd0, 32'(branch.taken));
        @(posedge clk);
        ex_fwd <= '0;
        @(negedge clk);
        check_word("stallreq released", 32'd0, 32'(stallreq));
        check_word("valid after stall", 32'd1, 32'(id_to_ex.valid));
        check_word("instr after stall", instr, id_to_ex.instr);
        check_word("op1 after stall", model[22], id_to_ex.op1);
        check_word("taken after stall", 32'd1, 32'(branch.taken));
        end_test();
    endtask

    task automatic test_hold();
        word_t first;
        word_t second;
        first  = r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU);
        second = r_type(5'd4, 5'd5, 5'd6, 5'd0, FN_XOR);
        start_test("downstream_hold");
        present(32'h0000_6000, first);
        @(posedge clk);
        stall <= 1'b1;
        fetch <= '{valid: 1'b1, pc: 32'h0000_6004, instr: second};
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
            @(negedge clk);
            check_word("instr while held", first, id_to_ex.instr);
            check_word("valid while held", 32'd1, 32'(id_to_ex.valid));
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_word("instr as stall falls", first, id_to_ex.instr);
        @(posedge clk);
        @(negedge clk);
        check_word("instr after release", second, id_to_ex.instr);
        check_word("pc after release", 32'h0000_6004, id_to_ex.pc);
        end_test();
    endtask

    initial begin
        void'($urandom(33806));
        rst          = 1'b1;
        // a valid jump waits at the input while reset is held
        fetch        = '{valid: 1'b1, pc: 32'h0000_0040, instr: j_type(OP_J, 26'h0000010)};
        stall        = 1'b0;
        ex_fwd       = '0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_decode();
        test_forwarding();
        test_branches();
        test_load_use();
        test_hold();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/decode_pkg.sv
logic/reg_file.sv
logic/operand_fwd.sv
logic/branch_unit.sv
logic/instr_decoder.sv
logic/decode_stage.sv
verification/decode_stage_chk.sv
verification/decode_stage_tb.sv

//--- Makefile
TOP = decode_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
